//--- sim.f
common/game_pkg.sv
hw/ps2/ps2_receiver.sv
hw/ps2/scan_decoder.sv
hw/button_pulse.sv
hw/seven_segment.sv
hw/setup_controller.sv
hw/game_top.sv
verification/game_checker.sv
verification/game_tb.sv

//--- run.sh
#!/bin/bash
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module game_tb -o game_sim &&
./obj_dir/game_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "run.sh: pass" || { echo "run.sh: fail"; exit 1; }

//--- verification/game_tb.sv
module game_tb;

        import game_pkg::*;

        logic        clk;
        logic        out_rst;
        logic        start_button;
        logic        ps2_clk;
        logic        ps2_data;
        logic [15:0] led;
        logic [3:0]  digit;
        logic [6:0]  segments;
        game_phase_t phase;
        logic [15:0] lfsr_state;

        game_top UUT (
                .clk         (clk),
                .out_rst     (out_rst),
                .start_button(start_button),
                .ps2_clk     (ps2_clk),
                .ps2_data    (ps2_data),
                .led         (led),
                .digit       (digit),
                .segments    (segments),
                .phase       (phase)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        task automatic abort_run(input string why);
                $display("%s", why);
                $display("SOME TESTS FAILED");
                $fatal(1, "simulation stopped");
        endtask

        always @(posedge clk)
                if (UUT.u_checker.errors != 0)
                        abort_run("checker assertion failed");

        // 16-bit fibonacci, taps 16 14 13 11
        function automatic logic next_bit();
                logic fb;
                fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
                lfsr_state = {lfsr_state[14:0], fb};
                return fb;
        endfunction

        function automatic logic [8:0] random_digit_key();
                logic [4:0] pick;
                pick = '0;
                for (int i = 0; i < 5; i++)
                        pick = {pick[3:0], next_bit()};
                return digit_codes[pick % 20];
        endfunction

        // start, data lsb first, odd parity, stop
        task automatic send_byte(input logic [7:0] b, input logic bad_parity);
                logic [10:0] f;
                f = {1'b1, ~^b ^ bad_parity, b, 1'b0};
                for (int i = 0; i < 11; i++) begin
                        @(posedge clk) ps2_data <= f[i];
                        repeat (3) @(posedge clk);
                        ps2_clk <= 1'b0;
                        repeat (4) @(posedge clk);
                        ps2_clk <= 1'b1;
                end
                repeat (8) @(posedge clk);
        endtask

        task automatic tap_key(input logic [8:0] code, input int repeats);
                for (int i = 0; i <= repeats; i++) begin
                        if (code[8])
                                send_byte(scan_ext_prefix, 1'b0);
                        send_byte(code[7:0], 1'b0);
                end
                if (code[8])
                        send_byte(scan_ext_prefix, 1'b0);
                send_byte(scan_break_prefix, 1'b0);
                send_byte(code[7:0], 1'b0);
        endtask

        task automatic wait_phase(input game_phase_t want, input int limit);
                int n;
                n = 0;
                while (phase != want) begin
                        @(negedge clk);
                        n++;
                        if (n > limit)
                                abort_run("timeout waiting for a phase change");
                end
        endtask

        task automatic press_start(input game_phase_t want);
                @(posedge clk) start_button <= 1'b1;
                @(posedge clk) start_button <= 1'b0; // short bounce first
                repeat (3) @(posedge clk);
                start_button <= 1'b1;
                repeat (12) @(posedge clk);
                start_button <= 1'b0;
                wait_phase(want, 50);
                repeat (80) @(posedge clk); // full display scan
        endtask

        initial begin
                out_rst      = 1'b1;
                start_button = 1'b0;
                ps2_clk      = 1'b1;
                ps2_data     = 1'b1;
                lfsr_state   = 16'd20589;
                repeat (8) @(posedge clk);
                out_rst <= 1'b0;
                repeat (80) @(posedge clk);
                press_start(phase_setup);
                for (int i = 0; i < 3; i++)
                        tap_key(random_digit_key(), 0);
                tap_key(9'h01C, 0);            // letter key
                tap_key(9'h170, 0);            // extended insert
                tap_key(digit_codes[1], 0);
                tap_key(digit_codes[12], 2);   // keypad 2 with typematic repeats
                tap_key(scan_space, 0);
                for (int i = 0; i < 3; i++)
                        tap_key(random_digit_key(), 0);
                send_byte(8'h16, 1'b1);
                repeat (80) @(posedge clk);
                press_start(phase_game);
                wait_phase(phase_final, 2000);
                repeat (80) @(posedge clk);
                press_start(phase_idle);
                if (UUT.u_checker.errors == 0) begin
                        $display("ALL TESTS PASSED");
                        $finish;
                end else begin
                        abort_run("checker recorded failures");
                end
        end

endmodule

//--- verification/game_checker.sv
module game_checker #(
        parameter int unsigned debounce_len = 4,
        parameter int unsigned tick_div     = 64,
        parameter int unsigned scan_div     = 16
) (
        input logic                  clk,
        input logic                  out_rst,
        input logic                  start_button,
        input logic                  ps2_clk,
        input logic                  ps2_data,
        input logic [15:0]           led,
        input logic [3:0]            digit,
        input logic [6:0]            segments,
        input game_pkg::game_phase_t phase
);

        import game_pkg::*;

        // gfedcba for 0..9
        localparam logic [6:0] seg_tab [10] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66,
                                                7'h6D, 7'h7D, 7'h07, 7'h7F, 7'h6F};
        localparam logic [3:0] sel_tab [4] = '{4'b1110, 4'b1101, 4'b1011, 4'b0111};

        int               errors = 0;
        game_phase_t      exp_phase;
        logic             exp_mode; // goal selected
        logic [7:0]       exp_time;
        logic [7:0]       exp_goal;
        int unsigned      ticks;
        int unsigned      scan_ticks;
        logic [1:0]       exp_sel;
        logic             btn_level;
        int unsigned      btn_cnt;
        logic             btn_rise;
        logic [2:0]       pulse_dly;
        logic             start_seen;
        logic             ps_prev;
        logic             ps_fall;
        logic [3:0]       ps_cnt;
        logic [10:0]      ps_bits;
        logic [10:0]      ps_next;
        logic             ps_good;
        logic [8:0]       ps_code;
        logic             ext_flag;
        logic             brk_flag;
        logic [511:0]     held;
        key_event_t [3:0] ev; // lines up with receiver and decoder latency
        key_event_t       seen;
        logic             press;
        logic             is_num;
        logic [3:0]       num;
        logic [15:0]      exp_word;
        logic [15:0]      exp_led;
        logic [3:0]       exp_nib;
        logic [6:0]       exp_seg;

        // new level must hold for debounce_len samples
        assign btn_rise   = start_button && !btn_level && (btn_cnt + 1 == debounce_len);
        assign start_seen = pulse_dly[2]; // sync and pulse stages of the button

        always_ff @(posedge clk or posedge out_rst) begin
                if (out_rst) begin
                        btn_level <= 1'b0;
                        btn_cnt   <= 0;
                        pulse_dly <= 3'b000;
                end else begin
                        pulse_dly <= {pulse_dly[1:0], btn_rise};
                        if (start_button == btn_level) begin
                                btn_cnt <= 0;
                        end else if (btn_cnt + 1 == debounce_len) begin
                                btn_level <= start_button;
                                btn_cnt   <= 0;
                        end else begin
                                btn_cnt <= btn_cnt + 1;
                        end
                end
        end

        // frame: start, 8 data lsb first, odd parity, stop
        assign ps_fall = ps_prev & ~ps2_clk;
        assign ps_next = {ps2_data, ps_bits[10:1]};
        assign ps_good = ps_fall && (ps_cnt == 4'd10) && !ps_next[0] && ps_next[10] &&
                         (^ps_next[9:1]);
        assign ps_code = {ext_flag, ps_next[8:1]};
        assign seen    = ev[3];

        always_ff @(posedge clk or posedge out_rst) begin
                if (out_rst) begin
                        ps_prev  <= 1'b1;
                        ps_cnt   <= 4'd0;
                        ext_flag <= 1'b0;
                        brk_flag <= 1'b0;
                        held     <= '0;
                        ev       <= '0;
                end else begin
                        ps_prev <= ps2_clk;
                        ev      <= {ev[2:0], 11'd0};
                        if (ps_fall) begin
                                ps_bits <= ps_next;
                                ps_cnt  <= (ps_cnt == 4'd10) ? 4'd0 : ps_cnt + 4'd1;
                        end
                        if (ps_good && ps_next[8:1] == scan_ext_prefix) begin
                                ext_flag <= 1'b1;
                        end else if (ps_good && ps_next[8:1] == scan_break_prefix) begin
                                brk_flag <= 1'b1;
                        end else if (ps_good) begin
                                ext_flag <= 1'b0;
                                brk_flag <= 1'b0;
                                if (brk_flag || !held[ps_code]) begin // repeats dropped
                                        held[ps_code] <= !brk_flag;
                                        ev[0]         <= {ps_code, !brk_flag, 1'b1};
                                end
                        end
                end
        end

        assign press = seen.valid & seen.make;

        always_comb begin
                is_num = 1'b0;
                num    = 4'd0;
                for (int i = 0; i < 20; i++) begin
                        if (seen.code == digit_codes[i]) begin
                                is_num = 1'b1;
                                num    = 4'(i >= 10 ? i - 10 : i); // keypad half
                        end
                end
                exp_word = (exp_phase == phase_idle) ? 16'hFFFF : {exp_time, exp_goal};
                exp_nib  = exp_word[4*exp_sel +: 4];
                exp_seg  = (exp_nib < 4'd10) ? seg_tab[exp_nib] : 7'h00;
                case (exp_phase)
                        phase_idle:  exp_led = 16'h0000;
                        phase_setup: exp_led = exp_mode ? 16'h80FF : 16'hFF01;
                        default:     exp_led = 16'hFFFF;
                endcase
        end

        always_ff @(posedge clk or posedge out_rst) begin
                if (out_rst) begin
                        exp_phase  <= phase_idle;
                        exp_mode   <= 1'b0;
                        ticks      <= 0;
                        scan_ticks <= 0;
                        exp_sel    <= 2'd0;
                end else begin
                        if (scan_ticks == scan_div - 1) begin
                                scan_ticks <= 0;
                                exp_sel    <= exp_sel + 2'd1;
                        end else begin
                                scan_ticks <= scan_ticks + 1;
                        end
                        if (exp_phase == phase_game && ticks < tick_div - 1)
                                ticks <= ticks + 1;
                        else
                                ticks <= 0;
                        case (exp_phase)
                                phase_idle: begin
                                        exp_mode <= 1'b0;
                                        exp_time <= 8'h30; // values on entry to setup
                                        exp_goal <= 8'h10;
                                        if (start_seen)
                                                exp_phase <= phase_setup;
                                end
                                phase_setup: begin
                                        if (press && seen.code == scan_space)
                                                exp_mode <= ~exp_mode;
                                        if (press && is_num && exp_mode)
                                                exp_goal <= {exp_goal[3:0], num};
                                        else if (press && is_num)
                                                exp_time <= {exp_time[3:0], num};
                                        if (start_seen)
                                                exp_phase <= phase_game;
                                end
                                phase_game: begin
                                        if (ticks == tick_div - 1 && exp_time == 8'h00)
                                                exp_phase <= phase_final;
                                        else if (ticks == tick_div - 1)
                                                exp_time <= (exp_time[3:0] == 4'd0) ?
                                                            exp_time - 8'h07 : exp_time - 8'h01;
                                end
                                default: begin
                                        if (start_seen)
                                                exp_phase <= phase_idle;
                                end
                        endcase
                end
        end

        a_phase: assert property (@(posedge clk) disable iff (out_rst) phase == exp_phase)
                else begin
                        errors++;
                        $error("mismatch at %0t: phase %0d, expected %0d", $time, phase, exp_phase);
                end

        a_led: assert property (@(posedge clk) disable iff (out_rst)
                        exp_phase != phase_game |-> led == exp_led)
                else begin
                        errors++;
                        $error("mismatch at %0t: led %h, expected %h", $time, led, exp_led);
                end

        // lfsr pattern above the fixed low bits
        a_game_led: assert property (@(posedge clk) disable iff (out_rst)
                        exp_phase == phase_game |-> led[6:0] == 7'b000_0011 && led[15:7] != 9'd0)
                else begin
                        errors++;
                        $error("mismatch at %0t: game led %h", $time, led);
                end

        a_digit: assert property (@(posedge clk) disable iff (out_rst)
                        digit == sel_tab[exp_sel])
                else begin
                        errors++;
                        $error("mismatch at %0t: digit select %b, expected %b", $time, digit,
                               sel_tab[exp_sel]);
                end

        a_segments: assert property (@(posedge clk) disable iff (out_rst) segments == exp_seg)
                else begin
                        errors++;
                        $error("mismatch at %0t: segments %h, expected %h", $time, segments, exp_seg);
                end

        a_reset_digit: assert property (@(posedge clk) $past(out_rst) && !out_rst |-> digit == 4'b1110)
                else begin
                        errors++;
                        $error("mismatch at %0t: digit %b after reset", $time, digit);
                end

endmodule

bind game_top game_checker #(
        .debounce_len(debounce_len),
        .tick_div    (tick_div),
        .scan_div    (scan_div)
) u_checker (.*);

//--- hw/game_top.sv
module game_top #(
        parameter int unsigned debounce_len = 4,
        parameter int unsigned tick_div     = 64,
        parameter int unsigned scan_div     = 16,
        parameter logic [8:0]  lfsr_seed    = 9'h1A5
) (
        input  logic                  clk,
        input  logic                  out_rst,
        input  logic                  start_button,
        input  logic                  ps2_clk,
        input  logic                  ps2_data,
        output logic [15:0]           led,
        output logic [3:0]            digit,
        output logic [6:0]            segments,
        output game_pkg::game_phase_t phase
);

        import game_pkg::*;

        logic          start_pulse;
        logic [7:0]    byte_data;
        logic          byte_strobe;
        key_event_t    key_event;
        logic          key_space_down;
        display_word_t display;

        button_pulse #(
                .debounce_len(debounce_len)
        ) u_button (
                .clk         (clk),
                .out_rst     (out_rst),
                .start_button(start_button),
                .start_pulse (start_pulse)
        );

        ps2_receiver u_ps2 (
                .clk        (clk),
                .out_rst    (out_rst),
                .ps2_clk    (ps2_clk),
                .ps2_data   (ps2_data),
                .byte_data  (byte_data),
                .byte_strobe(byte_strobe)
        );

        scan_decoder u_decoder (
                .clk           (clk),
                .out_rst       (out_rst),
                .byte_data     (byte_data),
                .byte_strobe   (byte_strobe),
                .key_event     (key_event),
                .key_space_down(key_space_down)
        );

        setup_controller #(
                .tick_div (tick_div),
                .lfsr_seed(lfsr_seed)
        ) u_ctrl (
                .clk           (clk),
                .out_rst       (out_rst),
                .start_pulse   (start_pulse),
                .key_event     (key_event),
                .key_space_down(key_space_down),
                .display       (display),
                .led           (led),
                .phase         (phase)
        );

        seven_segment #(
                .scan_div(scan_div)
        ) u_seg (
                .clk     (clk),
                .out_rst (out_rst),
                .display (display),
                .digit   (digit),
                .segments(segments)
        );

endmodule

//--- hw/setup_controller.sv
module setup_controller #(
        parameter int unsigned tick_div  = 64,
        parameter logic [8:0]  lfsr_seed = 9'h1A5
) (
        input  logic                     clk,
        input  logic                     out_rst,
        input  logic                     start_pulse,
        input  game_pkg::key_event_t     key_event,
        input  logic                     key_space_down,
        output game_pkg::display_word_t  display,
        output logic [15:0]              led,
        output game_pkg::game_phase_t    phase
);

        import game_pkg::*;

        localparam int tick_w = $clog2(tick_div + 1);

        logic              goal_mode;
        display_word_t     values;
        logic [tick_w-1:0] tick_cnt;
        logic              tick;
        logic [8:0]        lfsr;
        logic              is_digit;
        logic [3:0]        key_num;
        logic              key_press;
        logic              space_press;
        logic              digit_press;
        logic              time_zero;

        function automatic logic [7:0] bcd_dec(input logic [7:0] v);
                if (v[3:0] == 4'd0)
                        return {v[7:4] - 4'd1, 4'd9};
                return {v[7:4], v[3:0] - 4'd1};
        endfunction

        // main row and keypad map to the same digit
        always_comb begin
                is_digit = 1'b0;
                key_num  = 4'd0;
                for (int i = 0; i < 20; i++) begin
                        if (key_event.code == digit_codes[i]) begin
                                is_digit = 1'b1;
                                key_num  = 4'(i % 10);
                        end
                end
        end

        assign key_press   = key_event.valid & key_event.make & (phase == phase_setup);
        assign space_press = key_press & (key_event.code == scan_space) & key_space_down;
        assign digit_press = key_press & is_digit;
        assign tick        = (tick_cnt == tick_w'(tick_div - 1));
        assign time_zero   = (values.bcd.time_bcd == 8'h00);

        always_ff @(posedge clk or posedge out_rst) begin
                if (out_rst) begin
                        phase     <= phase_idle;
                        goal_mode <= 1'b0;
                        tick_cnt  <= '0;
                end else begin
                        if (phase == phase_game && !tick)
                                tick_cnt <= tick_cnt + 1'b1;
                        else
                                tick_cnt <= '0;
                        case (phase)
                                phase_idle: begin
                                        goal_mode <= 1'b0;
                                        if (start_pulse)
                                                phase <= phase_setup;
                                end
                                phase_setup: begin
                                        if (space_press)
                                                goal_mode <= ~goal_mode;
                                        if (start_pulse)
                                                phase <= phase_game;
                                end
                                phase_game: begin
                                        if (tick && time_zero)
                                                phase <= phase_final;
                                end
                                phase_final: begin
                                        if (start_pulse)
                                                phase <= phase_idle;
                                end
                                default: phase <= phase_idle;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (phase == phase_idle && start_pulse) begin
                        values.bcd.time_bcd <= 8'h30;
                        values.bcd.goal_bcd <= 8'h10;
                end else if (digit_press) begin
                        if (goal_mode)
                                values.bcd.goal_bcd <= {values.bcd.goal_bcd[3:0], key_num};
                        else
                                values.bcd.time_bcd <= {values.bcd.time_bcd[3:0], key_num};
                end else if (phase == phase_game && tick && !time_zero) begin
                        values.bcd.time_bcd <= bcd_dec(values.bcd.time_bcd);
                end
        end

        always_ff @(posedge clk) begin
                if (phase == phase_setup && start_pulse) begin
                        lfsr <= lfsr_seed;
                end else if (phase == phase_game && tick) begin
                        lfsr <= {lfsr[0], lfsr[8], lfsr[7] ^ lfsr[0], lfsr[6] ^ lfsr[0],
                                 lfsr[5], lfsr[4] ^ lfsr[0], lfsr[3], lfsr[2], lfsr[1]};
                end
        end

        always_comb begin
                if (phase == phase_idle)
                        display.nibble = {4{blank_digit}};
                else
                        display = values;
        end

        always_comb begin
                case (phase)
                        phase_idle:  led = 16'h0000;
                        phase_setup: led = goal_mode ? 16'h80FF : 16'hFF01;
                        phase_game:  led = {lfsr, 7'b000_0011};
                        default:     led = 16'hFFFF; // final
                endcase
        end

endmodule

//--- hw/seven_segment.sv
module seven_segment #(
        parameter int unsigned scan_div = 16
) (
        input  logic                    clk,
        input  logic                    out_rst,
        input  game_pkg::display_word_t display,
        output logic [3:0]              digit,
        output logic [6:0]              segments
);

        import game_pkg::*;

        localparam int scan_w = $clog2(scan_div + 1);

        logic [scan_w-1:0] scan_cnt;
        logic [1:0]        sel;
        logic [3:0]        nibble;

        always_ff @(posedge clk or posedge out_rst) begin
                if (out_rst) begin
                        scan_cnt <= '0;
                        sel      <= 2'd0;
                end else if (scan_cnt == scan_w'(scan_div - 1)) begin
                        scan_cnt <= '0;
                        sel      <= sel + 2'd1;
                end else begin
                        scan_cnt <= scan_cnt + 1'b1;
                end
        end

        assign digit  = ~(4'b0001 << sel); // one low at a time
        assign nibble = display.nibble[sel];

        // gfedcba
        always_comb begin
                case (nibble)
                        4'd0:        segments = 7'h3F;
                        4'd1:        segments = 7'h06;
                        4'd2:        segments = 7'h5B;
                        4'd3:        segments = 7'h4F;
                        4'd4:        segments = 7'h66;
                        4'd5:        segments = 7'h6D;
                        4'd6:        segments = 7'h7D;
                        4'd7:        segments = 7'h07;
                        4'd8:        segments = 7'h7F;
                        4'd9:        segments = 7'h6F;
                        blank_digit: segments = 7'h00;
                        default:     segments = 7'h00;
                endcase
        end

endmodule

//--- hw/button_pulse.sv
module button_pulse #(
        parameter int unsigned debounce_len = 4
) (
        input  logic clk,
        input  logic out_rst,
        input  logic start_button,
        output logic start_pulse
);

        localparam int cnt_w = $clog2(debounce_len + 1);

        logic [1:0]       btn_sync;
        logic             btn_level;
        logic [cnt_w-1:0] stable_cnt;
        logic             settled;

        // new level held long enough
        assign settled = (btn_sync[1] != btn_level) &&
                         (stable_cnt == cnt_w'(debounce_len - 1));

        always_ff @(posedge clk or posedge out_rst) begin
                if (out_rst) begin
                        btn_sync    <= 2'b00;
                        btn_level   <= 1'b0;
                        stable_cnt  <= '0;
                        start_pulse <= 1'b0;
                end else begin
                        btn_sync    <= {btn_sync[0], start_button};
                        start_pulse <= settled & btn_sync[1]; // rising edge only
                        if (btn_sync[1] == btn_level || settled)
                                stable_cnt <= '0;
                        else
                                stable_cnt <= stable_cnt + 1'b1;
                        if (settled)
                                btn_level <= btn_sync[1];
                end
        end

endmodule

//--- hw/ps2/scan_decoder.sv
module scan_decoder (
        input  logic                 clk,
        input  logic                 out_rst,
        input  logic [7:0]           byte_data,
        input  logic                 byte_strobe,
        output game_pkg::key_event_t key_event,
        output logic                 key_space_down
);

        import game_pkg::*;

        logic         ext_seen;
        logic         break_seen;
        logic [511:0] key_down;
        logic [8:0]   code;
        logic         is_prefix;

        assign code      = {ext_seen, byte_data};
        assign is_prefix = (byte_data == scan_ext_prefix) || (byte_data == scan_break_prefix);

        always_ff @(posedge clk or posedge out_rst) begin
                if (out_rst) begin
                        ext_seen   <= 1'b0;
                        break_seen <= 1'b0;
                        key_down   <= '0;
                        key_event  <= '0;
                end else begin
                        key_event.valid <= 1'b0;
                        if (byte_strobe) begin
                                if (byte_data == scan_ext_prefix) begin
                                        ext_seen <= 1'b1;
                                end else if (byte_data == scan_break_prefix) begin
                                        break_seen <= 1'b1;
                                end
                                if (!is_prefix) begin
                                        ext_seen   <= 1'b0;
                                        break_seen <= 1'b0;
                                        key_event.code <= code;
                                        if (break_seen) begin
                                                key_down[code]  <= 1'b0;
                                                key_event.make  <= 1'b0;
                                                key_event.valid <= 1'b1;
                                        end else if (!key_down[code]) begin
                                                key_down[code]  <= 1'b1;
                                                key_event.make  <= 1'b1;
                                                key_event.valid <= 1'b1;
                                        end
                                        // held key repeats fall through silently
                                end
                        end
                end
        end

        assign key_space_down = key_down[scan_space];

endmodule

//--- hw/ps2/ps2_receiver.sv
module ps2_receiver (
        input  logic       clk,
        input  logic       out_rst,
        input  logic       ps2_clk,
        input  logic       ps2_data,
        output logic [7:0] byte_data,
        output logic       byte_strobe
);

        logic [1:0]  clk_sync;
        logic [1:0]  data_sync;
        logic        clk_prev;
        logic        fall;
        logic [3:0]  bit_cnt;
        logic [10:0] frame;
        logic [10:0] next_frame;
        logic        last_bit;
        logic        frame_ok;

        // both lines idle high
        always_ff @(posedge clk or posedge out_rst) begin
                if (out_rst) begin
                        clk_sync  <= 2'b11;
                        data_sync <= 2'b11;
                        clk_prev  <= 1'b1;
                end else begin
                        clk_sync  <= {clk_sync[0], ps2_clk};
                        data_sync <= {data_sync[0], ps2_data};
                        clk_prev  <= clk_sync[1];
                end
        end

        assign fall       = clk_prev & ~clk_sync[1];
        assign next_frame = {data_sync[1], frame[10:1]}; // lsb first
        assign last_bit   = (bit_cnt == 4'd10);

        // start low, stop high, odd parity over data and parity bit
        assign frame_ok = ~next_frame[0] & next_frame[10] & (^next_frame[9:1]);

        always_ff @(posedge clk or posedge out_rst) begin
                if (out_rst) begin
                        bit_cnt     <= 4'd0;
                        byte_strobe <= 1'b0;
                end else begin
                        byte_strobe <= fall & last_bit & frame_ok;
                        if (fall) begin
                                if (last_bit)
                                        bit_cnt <= 4'd0;
                                else
                                        bit_cnt <= bit_cnt + 4'd1;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (fall) begin
                        frame <= next_frame;
                        if (last_bit)
                                byte_data <= next_frame[8:1];
                end
        end

endmodule

//--- common/game_pkg.sv
package game_pkg;

        typedef enum logic [1:0] {
                phase_idle  = 2'd0,
                phase_setup = 2'd1,
                phase_game  = 2'd2,
                phase_final = 2'd3
        } game_phase_t;

        // bit 8 of code is the E0 extended flag
        typedef struct packed {
                logic [8:0] code;
                logic       make;
                logic       valid;
        } key_event_t;

        typedef struct packed {
                logic [7:0] time_bcd;
                logic [7:0] goal_bcd;
        } bcd_pair_t;

        // digit view for the display scan, value view for number entry
        typedef union packed {
                logic [3:0][3:0] nibble;
                bcd_pair_t       bcd;
        } display_word_t;

        localparam logic [8:0] scan_space        = 9'h029;
        localparam logic [7:0] scan_break_prefix = 8'hF0;
        localparam logic [7:0] scan_ext_prefix   = 8'hE0;

        // main row 0..9, then keypad 0..9
        localparam logic [8:0] digit_codes [20] = '{
                9'h045, 9'h016, 9'h01E, 9'h026, 9'h025,
                9'h02E, 9'h036, 9'h03D, 9'h03E, 9'h046,
                9'h070, 9'h069, 9'h072, 9'h07A, 9'h06B,
                9'h073, 9'h074, 9'h06C, 9'h075, 9'h07D
        };

        localparam logic [3:0] blank_digit = 4'hF;

endpackage
